//--- include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// instruction cache line width in bits
// one line holds eight words, so four fetch groups of 8 bytes
`define ICACHE_LINE_WIDTH 256

// a fetch group is two instructions, the byte offset inside a group
// takes pc bits 2 to 0
`define FETCH_GROUP_BYTES 8

`endif

//--- src/bpu_pkg.sv
package bpu_pkg;

	// byte address as seen by the fetch stage
	typedef logic [31:0] virt_t;

	// 2-bit saturating counter
	// 0 and 1 predict not taken, 2 and 3 predict taken
	typedef logic [1:0] counter_t;

	// kind of control flow stored in the btb
	typedef enum logic [2:0] {
		CF_NONE   = 3'd0,
		CF_BRANCH = 3'd1,
		CF_JUMP   = 3'd2,
		CF_CALL   = 3'd3,
		CF_RETURN = 3'd4
	} cf_t;

	// weakly not taken after reset
	localparam counter_t COUNTER_INIT = 2'd1;

	// saturation limits
	localparam counter_t COUNTER_MIN = 2'd0;
	localparam counter_t COUNTER_MAX = 2'd3;

	// step a counter one position toward the resolved outcome
	// and hold it at the limits
	function automatic counter_t counter_step(
		input counter_t cur,
		input logic     taken
	);
		counter_t nxt;
		nxt = cur;
		if (taken) begin
			if (cur != COUNTER_MAX) begin
				nxt = cur + 2'd1;
			end
		end else begin
			if (cur != COUNTER_MIN) begin
				nxt = cur - 2'd1;
			end
		end
		return nxt;
	endfunction

	// a counter predicts taken when its high bit is set
	function automatic logic counter_taken(
		input counter_t cur
	);
		return cur[1];
	endfunction

endpackage

//--- src/bpu_resolve_if.sv
`timescale 1ns/1ps

// resolved branch coming back from execute
// valid is a single-cycle pulse, there is no back-pressure
interface bpu_resolve_if;

	logic              valid;
	bpu_pkg::virt_t    pc;
	bpu_pkg::virt_t    target;
	bpu_pkg::cf_t      cf;
	logic              taken;
	// counter that was predicted for this branch
	bpu_pkg::counter_t counter;

	modport src (
		output valid,
		output pc,
		output target,
		output cf,
		output taken,
		output counter
	);

	modport dst (
		input valid,
		input pc,
		input target,
		input cf,
		input taken,
		input counter
	);

endinterface

//--- src/bht.sv
`timescale 1ns/1ps

module bht #(
	parameter int SIZE = 64
) (
	input  logic                    clk,
	input  logic                    rst,
	input  bpu_pkg::virt_t          vaddr,
	bpu_resolve_if.dst              resolve,
	output bpu_pkg::counter_t [1:0] counter
);

	localparam int INDEX_W = $clog2(SIZE);

	// two counters per fetch group, indexed by slot
	bpu_pkg::counter_t [1:0] ctr_q [SIZE];

	logic [INDEX_W-1:0] rd_index;
	logic [INDEX_W-1:0] wr_index;
	logic               wr_slot;
	logic               wr_en;
	bpu_pkg::counter_t  wr_value;

	// group index skips the byte offset within the 8-byte group
	assign rd_index = vaddr[3 +: INDEX_W];
	assign wr_index = resolve.pc[3 +: INDEX_W];
	assign wr_slot  = resolve.pc[2];

	// jumps, calls and returns never touch the counters
	assign wr_en    = resolve.valid && (resolve.cf == bpu_pkg::CF_BRANCH);
	assign wr_value = bpu_pkg::counter_step(resolve.counter, resolve.taken);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < SIZE; i++) begin
				ctr_q[i] <= {2{bpu_pkg::COUNTER_INIT}};
			end
		end else if (wr_en) begin
			ctr_q[wr_index][wr_slot] <= wr_value;
		end
	end

	// registered lookup so a same-cycle write is seen one cycle later
	always_ff @(posedge clk) begin
		if (rst) begin
			counter <= {2{bpu_pkg::COUNTER_INIT}};
		end else begin
			counter <= ctr_q[rd_index];
		end
	end

endmodule

//--- src/btb.sv
`timescale 1ns/1ps

module btb #(
	parameter int SIZE = 64
) (
	input  logic                 clk,
	input  logic                 rst,
	input  bpu_pkg::virt_t       vaddr,
	bpu_resolve_if.dst           resolve,
	input  logic                 presolved_valid,
	input  bpu_pkg::virt_t       presolved_pc,
	output bpu_pkg::cf_t [1:0]   cf,
	output bpu_pkg::virt_t [1:0] target
);

	localparam int INDEX_W = $clog2(SIZE);
	localparam int TAG_W   = 32 - 3 - INDEX_W;

	typedef logic [TAG_W-1:0] tag_t;

	// per slot storage
	logic [1:0]           valid_q  [SIZE];
	tag_t [1:0]           tag_q    [SIZE];
	bpu_pkg::virt_t [1:0] target_q [SIZE];
	bpu_pkg::cf_t [1:0]   cf_q     [SIZE];

	logic [INDEX_W-1:0] rd_index;
	tag_t               rd_tag;
	logic [INDEX_W-1:0] wr_index;
	tag_t               wr_tag;
	logic               wr_slot;
	logic [INDEX_W-1:0] pre_index;
	logic               pre_slot;
	bpu_pkg::cf_t [1:0] lookup_cf;

	assign rd_index  = vaddr[3 +: INDEX_W];
	assign rd_tag    = vaddr[31 -: TAG_W];
	assign wr_index  = resolve.pc[3 +: INDEX_W];
	assign wr_tag    = resolve.pc[31 -: TAG_W];
	assign wr_slot   = resolve.pc[2];
	assign pre_index = presolved_pc[3 +: INDEX_W];
	assign pre_slot  = presolved_pc[2];

	// valid bits
	// the presolve clear comes last so it wins over a resolve to the same slot
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < SIZE; i++) begin
				valid_q[i] <= 2'b00;
			end
		end else begin
			if (resolve.valid) begin
				valid_q[wr_index][wr_slot] <= 1'b1;
			end
			if (presolved_valid) begin
				valid_q[pre_index][pre_slot] <= 1'b0;
			end
		end
	end

	// every resolve rewrites the slot payload
	always_ff @(posedge clk) begin
		if (resolve.valid) begin
			tag_q[wr_index][wr_slot]    <= wr_tag;
			target_q[wr_index][wr_slot] <= resolve.target;
			cf_q[wr_index][wr_slot]     <= resolve.cf;
		end
	end

	// empty slot or tag mismatch reads as no control flow
	always_comb begin
		for (int s = 0; s < 2; s++) begin
			if (valid_q[rd_index][s] && (tag_q[rd_index][s] == rd_tag)) begin
				lookup_cf[s] = cf_q[rd_index][s];
			end else begin
				lookup_cf[s] = bpu_pkg::CF_NONE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cf[0] <= bpu_pkg::CF_NONE;
			cf[1] <= bpu_pkg::CF_NONE;
		end else begin
			cf <= lookup_cf;
		end
	end

	// targets of both slots of the group at vaddr
	always_ff @(posedge clk) begin
		target <= target_q[rd_index];
	end

endmodule

//--- src/branch_predictor.sv
`include "cpu_defs.svh"
`timescale 1ns/1ps

module branch_predictor #(
	parameter int SIZE              = 64,
	parameter int ICACHE_LINE_WIDTH = `ICACHE_LINE_WIDTH
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              stall,
	input  logic              flush,
	// fetch address of this cycle, looked up in both tables
	input  bpu_pkg::virt_t    pc_cur,
	// fetch address of the previous cycle, the prediction belongs to it
	input  bpu_pkg::virt_t    pc_prev,
	bpu_resolve_if.dst        resolve,
	input  logic              presolved_valid,
	input  bpu_pkg::virt_t    presolved_pc,
	output logic              pred_valid,
	output bpu_pkg::virt_t    pred_target,
	output bpu_pkg::cf_t      pred_cf,
	output logic              pred_taken,
	output bpu_pkg::counter_t pred_counter,
	output logic [1:0]        prediction_sel
);

	localparam int ICACHE_ADDR_WIDTH = $clog2(ICACHE_LINE_WIDTH / 8);

	// live table outputs and the copies held across a stall
	bpu_pkg::counter_t [1:0] bht_counter;
	bpu_pkg::counter_t [1:0] bht_counter_delay;
	bpu_pkg::cf_t [1:0]      btb_cf;
	bpu_pkg::cf_t [1:0]      btb_cf_delay;
	bpu_pkg::virt_t [1:0]    btb_target;
	bpu_pkg::virt_t [1:0]    btb_target_delay;

	// outputs as seen by the selection logic
	bpu_pkg::counter_t [1:0] counter_src;
	bpu_pkg::cf_t [1:0]      cf_src;
	bpu_pkg::virt_t [1:0]    target_src;

	logic pipe_stall;
	logic pipe_flush;
	logic sel;
	logic line_end;

	bht #(
		.SIZE(SIZE)
	) bht_inst (
		.clk,
		.rst,
		.vaddr   (pc_cur),
		.resolve (resolve),
		.counter (bht_counter)
	);

	btb #(
		.SIZE(SIZE)
	) btb_inst (
		.clk,
		.rst,
		.vaddr           (pc_cur),
		.resolve         (resolve),
		.presolved_valid (presolved_valid),
		.presolved_pc    (presolved_pc),
		.cf              (btb_cf),
		.target          (btb_target)
	);

	// the delayed copies freeze while stall is high
	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_flush        <= 1'b0;
			bht_counter_delay <= {2{bpu_pkg::COUNTER_INIT}};
			btb_cf_delay[0]   <= bpu_pkg::CF_NONE;
			btb_cf_delay[1]   <= bpu_pkg::CF_NONE;
			btb_target_delay  <= '0;
		end else if (!stall) begin
			pipe_flush        <= flush;
			bht_counter_delay <= bht_counter;
			btb_cf_delay      <= btb_cf;
			btb_target_delay  <= btb_target;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_stall <= 1'b0;
		end else begin
			pipe_stall <= stall;
		end
	end

	assign counter_src = pipe_stall ? bht_counter_delay : bht_counter;
	assign cf_src      = pipe_stall ? btb_cf_delay : btb_cf;
	assign target_src  = pipe_stall ? btb_target_delay : btb_target;

	// last 8-byte group of a cache line
	assign line_end = &pc_prev[ICACHE_ADDR_WIDTH-1:3];

	always_comb begin
		// entering at the second word leaves only slot 1 usable
		if (pc_prev[2]) begin
			sel = 1'b1;
		end else begin
			sel = (cf_src[0] != bpu_pkg::CF_NONE) ? 1'b0 : 1'b1;
		end

		prediction_sel      = 2'b00;
		prediction_sel[sel] = 1'b1;

		pred_valid   = cf_src[sel] != bpu_pkg::CF_NONE;
		pred_target  = target_src[sel];
		pred_cf      = cf_src[sel];
		pred_counter = counter_src[sel];
		if (cf_src[sel] == bpu_pkg::CF_BRANCH) begin
			pred_taken = bpu_pkg::counter_taken(counter_src[sel]);
		end else begin
			pred_taken = 1'b1;
		end

		// slot 1 at line end has its delay slot in the next line
		if ((line_end && sel) || pipe_flush) begin
			pred_valid = 1'b0;
		end
	end

endmodule

//--- src/bpu_top.sv
`include "cpu_defs.svh"
`timescale 1ns/1ps

module bpu_top #(
	parameter int SIZE              = 64,
	parameter int ICACHE_LINE_WIDTH = `ICACHE_LINE_WIDTH
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              stall,
	input  logic              flush,
	input  bpu_pkg::virt_t    pc_cur,
	input  bpu_pkg::virt_t    pc_prev,
	// resolved branch from execute
	input  logic              resolved_valid,
	input  bpu_pkg::virt_t    resolved_pc,
	input  bpu_pkg::virt_t    resolved_target,
	input  bpu_pkg::cf_t      resolved_cf,
	input  logic              resolved_taken,
	input  bpu_pkg::counter_t resolved_counter,
	// decode found no control flow at this pc
	input  logic              presolved_valid,
	input  bpu_pkg::virt_t    presolved_pc,
	output logic              pred_valid,
	output bpu_pkg::virt_t    pred_target,
	output bpu_pkg::cf_t      pred_cf,
	output logic              pred_taken,
	output bpu_pkg::counter_t pred_counter,
	output logic [1:0]        prediction_sel
);

	bpu_resolve_if resolve_bus ();

	assign resolve_bus.valid   = resolved_valid;
	assign resolve_bus.pc      = resolved_pc;
	assign resolve_bus.target  = resolved_target;
	assign resolve_bus.cf      = resolved_cf;
	assign resolve_bus.taken   = resolved_taken;
	assign resolve_bus.counter = resolved_counter;

	branch_predictor #(
		.SIZE              (SIZE),
		.ICACHE_LINE_WIDTH (ICACHE_LINE_WIDTH)
	) predictor_inst (
		.clk,
		.rst,
		.stall,
		.flush,
		.pc_cur,
		.pc_prev,
		.resolve         (resolve_bus),
		.presolved_valid (presolved_valid),
		.presolved_pc    (presolved_pc),
		.pred_valid,
		.pred_target,
		.pred_cf,
		.pred_taken,
		.pred_counter,
		.prediction_sel
	);

endmodule

//--- bench/bpu_sva.sv
`timescale 1ns/1ps

module bpu_sva (
	input logic         clk,
	input logic         rst,
	input logic         pred_valid,
	input bpu_pkg::cf_t pred_cf,
	input logic         pred_taken,
	input logic [1:0]   prediction_sel
);

	// exactly one slot is selected
	assert property (@(posedge clk) disable iff (rst)
		$onehot(prediction_sel))
	else $error("prediction_sel is not one-hot");

	// nothing predicted straight out of reset
	assert property (@(posedge clk)
		rst |=> !pred_valid)
	else $error("pred_valid high after reset");

	// only conditional branches can be predicted not taken
	assert property (@(posedge clk) disable iff (rst)
		(pred_valid && pred_cf != bpu_pkg::CF_BRANCH) |-> pred_taken)
	else $error("pred_taken low for a non-branch prediction");

endmodule

bind bpu_top bpu_sva sva_inst (
	.clk            (clk),
	.rst            (rst),
	.pred_valid     (pred_valid),
	.pred_cf        (pred_cf),
	.pred_taken     (pred_taken),
	.prediction_sel (prediction_sel)
);

//--- bench/bpu_tb.sv
`include "cpu_defs.svh"
`timescale 1ns/1ps

module bpu_tb;

	localparam int SIZE            = 64;
	localparam int LINE_BYTES      = `ICACHE_LINE_WIDTH / 8;
	localparam int GROUPS_PER_LINE = LINE_BYTES / `FETCH_GROUP_BYTES;

	logic              clk;
	logic              rst;
	logic              stall;
	logic              flush;
	bpu_pkg::virt_t    pc_cur;
	bpu_pkg::virt_t    pc_prev;
	logic              resolved_valid;
	bpu_pkg::virt_t    resolved_pc;
	bpu_pkg::virt_t    resolved_target;
	bpu_pkg::cf_t      resolved_cf;
	logic              resolved_taken;
	bpu_pkg::counter_t resolved_counter;
	logic              presolved_valid;
	bpu_pkg::virt_t    presolved_pc;
	logic              pred_valid;
	bpu_pkg::virt_t    pred_target;
	bpu_pkg::cf_t      pred_cf;
	logic              pred_taken;
	bpu_pkg::counter_t pred_counter;
	logic [1:0]        prediction_sel;

	// shadow tables, one entry per group and slot
	logic              sh_valid  [SIZE][2];
	logic [28:0]       sh_group  [SIZE][2];
	bpu_pkg::virt_t    sh_target [SIZE][2];
	bpu_pkg::cf_t      sh_cf     [SIZE][2];
	bpu_pkg::counter_t sh_ctr    [SIZE][2];

	// expected outputs, read by the compare process
	logic              check_en;
	logic              exp_valid;
	logic              exp_hit;
	bpu_pkg::virt_t    exp_target;
	bpu_pkg::cf_t      exp_cf;
	logic              exp_taken;
	bpu_pkg::counter_t exp_counter;
	logic [1:0]        exp_sel;

	logic [31:0] rng;
	int          checks;
	int          errors;
	int          test_num;
	int          test_start_errors;
	string       test_name;

	bpu_top #(
		.SIZE(SIZE)
	) uut (
		.*
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rand_word();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic bpu_pkg::counter_t counter_next(input bpu_pkg::counter_t c, input logic t);
		if (t) begin
			return (c == 2'd3) ? c : c + 2'd1;
		end
		return (c == 2'd0) ? c : c - 2'd1;
	endfunction

	// expected prediction for a group fetched at pc
	function automatic void ref_predict(
		input  bpu_pkg::virt_t     pc,
		output logic               v,
		output logic               hit,
		output bpu_pkg::virt_t     tgt,
		output bpu_pkg::cf_t       cf,
		output logic               tk,
		output bpu_pkg::counter_t  ctr,
		output logic [1:0]         sel_onehot
	);
		int           idx;
		int           sel;
		logic         last;
		bpu_pkg::cf_t cfs [2];
		idx = int'(pc[8:3]);
		for (int s = 0; s < 2; s++) begin
			if (sh_valid[idx][s] && sh_group[idx][s] == pc[31:3]) begin
				cfs[s] = sh_cf[idx][s];
			end else begin
				cfs[s] = bpu_pkg::CF_NONE;
			end
		end
		sel = (pc[2] || cfs[0] == bpu_pkg::CF_NONE) ? 1 : 0;
		last = ((pc / 8) % GROUPS_PER_LINE) == GROUPS_PER_LINE - 1;
		cf = cfs[sel];
		hit = cf != bpu_pkg::CF_NONE;
		v = hit && !(sel == 1 && last);
		tgt = sh_target[idx][sel];
		ctr = sh_ctr[idx][sel];
		tk = (cf == bpu_pkg::CF_BRANCH) ? ctr[1] : 1'b1;
		sel_onehot = (sel == 1) ? 2'b10 : 2'b01;
	endfunction

	// compare process
	always @(negedge clk) begin
		if (check_en && !rst) begin
			checks++;
			assert (pred_valid === exp_valid) else begin
				$display("MISMATCH pred_valid got %h expected %h", pred_valid, exp_valid);
				errors++;
			end
			assert (pred_cf === exp_cf) else begin
				$display("MISMATCH pred_cf got %h expected %h", pred_cf, exp_cf);
				errors++;
			end
			assert (pred_taken === exp_taken) else begin
				$display("MISMATCH pred_taken got %h expected %h", pred_taken, exp_taken);
				errors++;
			end
			assert (pred_counter === exp_counter) else begin
				$display("MISMATCH pred_counter got %h expected %h", pred_counter, exp_counter);
				errors++;
			end
			assert (prediction_sel === exp_sel) else begin
				$display("MISMATCH prediction_sel got %h expected %h", prediction_sel, exp_sel);
				errors++;
			end
			// target is only meaningful on a hit
			if (exp_hit) begin
				assert (pred_target === exp_target) else begin
					$display("MISMATCH pred_target got %h expected %h", pred_target, exp_target);
					errors++;
				end
			end
		end
	end

	task automatic set_expected(input bpu_pkg::virt_t pc, input logic flushed);
		logic              v;
		logic              hit;
		bpu_pkg::virt_t    tgt;
		bpu_pkg::cf_t      cf;
		logic              tk;
		bpu_pkg::counter_t ctr;
		logic [1:0]        sel;
		ref_predict(pc, v, hit, tgt, cf, tk, ctr, sel);
		exp_valid   <= v && !flushed;
		exp_hit     <= hit;
		exp_target  <= tgt;
		exp_cf      <= cf;
		exp_taken   <= tk;
		exp_counter <= ctr;
		exp_sel     <= sel;
		check_en    <= 1'b1;
	endtask

	task automatic train_entry(
		input bpu_pkg::virt_t pc,
		input bpu_pkg::virt_t tgt,
		input bpu_pkg::cf_t   cf,
		input logic           taken
	);
		int                idx;
		bpu_pkg::counter_t c;
		idx = int'(pc[8:3]);
		// feed back the counter that the predictor holds for this slot
		c = sh_ctr[idx][pc[2]];
		@(posedge clk);
		resolved_valid   <= 1'b1;
		resolved_pc      <= pc;
		resolved_target  <= tgt;
		resolved_cf      <= cf;
		resolved_taken   <= taken;
		resolved_counter <= c;
		@(posedge clk);
		resolved_valid <= 1'b0;
		sh_valid[idx][pc[2]]  = 1'b1;
		sh_group[idx][pc[2]]  = pc[31:3];
		sh_target[idx][pc[2]] = tgt;
		sh_cf[idx][pc[2]]     = cf;
		if (cf == bpu_pkg::CF_BRANCH) begin
			sh_ctr[idx][pc[2]] = counter_next(c, taken);
		end
	endtask

	task automatic presolve_entry(input bpu_pkg::virt_t pc);
		@(posedge clk);
		presolved_valid <= 1'b1;
		presolved_pc    <= pc;
		@(posedge clk);
		presolved_valid <= 1'b0;
		sh_valid[int'(pc[8:3])][pc[2]] = 1'b0;
	endtask

	// lookup on pc_cur, prediction checked the cycle after
	task automatic fetch_group(input bpu_pkg::virt_t pc, input logic with_flush);
		@(posedge clk);
		pc_cur <= pc;
		flush  <= with_flush;
		@(posedge clk);
		flush   <= 1'b0;
		pc_prev <= pc;
		set_expected(pc, with_flush);
		@(posedge clk);
		check_en <= 1'b0;
	endtask

	// outputs must hold while the lookup address wanders during a stall
	task automatic stall_hold(input bpu_pkg::virt_t pc, input int cycles);
		@(posedge clk);
		pc_cur <= pc;
		@(posedge clk);
		pc_prev <= pc;
		set_expected(pc, 1'b0);
		@(posedge clk);
		stall  <= 1'b1;
		pc_cur <= rand_word() & 32'hffff_fffc;
		repeat (cycles) begin
			@(posedge clk);
			pc_cur <= rand_word() & 32'hffff_fffc;
		end
		@(posedge clk);
		stall  <= 1'b0;
		pc_cur <= pc;
		@(posedge clk);
		@(posedge clk);
		check_en <= 1'b0;
	endtask

	task automatic start_test(input string name);
		test_num++;
		test_name = name;
		test_start_errors = errors;
	endtask

	task automatic end_test();
		$display("test %0d %s: %s", test_num, test_name,
			(errors == test_start_errors) ? "ok" : "FAILED");
	endtask

	initial begin : watchdog
		int n;
		n = 0;
		while (n < 5000) begin
			@(posedge clk);
			n++;
		end
		$display("timeout: the test sequence did not finish in 5000 cycles");
		$display("Regression failed");
		$finish;
	end

	initial begin : stimulus
		bpu_pkg::virt_t pcs [8];
		bpu_pkg::virt_t g;
		bpu_pkg::virt_t h;
		bpu_pkg::virt_t l;
		bpu_pkg::virt_t b;
		clk = 1'b0;
		rst = 1'b1;
		stall = 1'b0;
		flush = 1'b0;
		pc_cur = '0;
		pc_prev = '0;
		resolved_valid = 1'b0;
		resolved_pc = '0;
		resolved_target = '0;
		resolved_cf = bpu_pkg::CF_NONE;
		resolved_taken = 1'b0;
		resolved_counter = '0;
		presolved_valid = 1'b0;
		presolved_pc = '0;
		check_en = 1'b0;
		rng = 32'had3c97ef;
		checks = 0;
		errors = 0;
		test_num = 0;
		for (int i = 0; i < SIZE; i++) begin
			for (int s = 0; s < 2; s++) begin
				sh_valid[i][s] = 1'b0;
				sh_group[i][s] = '0;
				sh_target[i][s] = '0;
				sh_cf[i][s] = bpu_pkg::CF_NONE;
				sh_ctr[i][s] = bpu_pkg::COUNTER_INIT;
			end
		end
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		start_test("empty after reset");
		repeat (16) fetch_group(rand_word() & 32'hffff_fffc, 1'b0);
		end_test();

		start_test("jumps calls returns");
		for (int i = 0; i < 8; i++) begin
			pcs[i] = rand_word() & 32'hffff_fffc;
			train_entry(pcs[i], rand_word() & 32'hffff_fffc,
				bpu_pkg::cf_t'(3'd2 + 3'(rand_word() % 3)), 1'b1);
		end
		for (int i = 0; i < 8; i++) begin
			fetch_group(pcs[i], 1'b0);
			// flipping a tag bit keeps the index and must miss
			fetch_group(pcs[i] ^ 32'h0000_0200, 1'b0);
		end
		end_test();

		start_test("counter saturation");
		b = rand_word() & 32'hffff_ffe0;
		repeat (5) begin
			train_entry(b, b + 32'h40, bpu_pkg::CF_BRANCH, 1'b1);
			fetch_group(b, 1'b0);
		end
		repeat (5) begin
			train_entry(b, b + 32'h40, bpu_pkg::CF_BRANCH, 1'b0);
			fetch_group(b, 1'b0);
		end
		end_test();

		start_test("slot selection");
		g = rand_word() & 32'hffff_ffe0;
		train_entry(g, rand_word() & 32'hffff_fffc, bpu_pkg::CF_JUMP, 1'b1);
		train_entry(g + 32'd4, rand_word() & 32'hffff_fffc, bpu_pkg::CF_CALL, 1'b1);
		fetch_group(g, 1'b0);
		fetch_group(g + 32'd4, 1'b0);
		h = rand_word() & 32'hffff_ffe0;
		train_entry(h + 32'd4, rand_word() & 32'hffff_fffc, bpu_pkg::CF_RETURN, 1'b1);
		fetch_group(h, 1'b0);
		// last group of a line
		l = (rand_word() & 32'hffff_fff8) | 32'h0000_0018;
		train_entry(l, rand_word() & 32'hffff_fffc, bpu_pkg::CF_JUMP, 1'b1);
		train_entry(l + 32'd4, rand_word() & 32'hffff_fffc, bpu_pkg::CF_CALL, 1'b1);
		fetch_group(l + 32'd4, 1'b0);
		fetch_group(l, 1'b0);
		end_test();

		start_test("presolve invalidate");
		presolve_entry(g);
		fetch_group(g, 1'b0);
		fetch_group(g + 32'd4, 1'b0);
		end_test();

		start_test("stall and flush");
		stall_hold(g + 32'd4, 4);
		stall_hold(b, 3);
		fetch_group(g + 32'd4, 1'b1);
		fetch_group(g + 32'd4, 1'b0);
		end_test();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+include
src/bpu_pkg.sv
src/bpu_resolve_if.sv
src/bht.sv
src/btb.sv
src/branch_predictor.sv
src/bpu_top.sv
bench/bpu_sva.sv
bench/bpu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module bpu_tb -o bpu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/bpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Regression passed" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
